// File: src/cd_bus_pkg.sv
package cd_bus_pkg;

    // Frame buffers and their addressing
    localparam int BUF_DEPTH  = 256;
    localparam int ADDR_WIDTH = $clog2(BUF_DEPTH);

    // Character framing and line timing
    localparam int DATA_BITS  = 8;
    localparam int DIV_WIDTH  = 16;
    localparam logic [DIV_WIDTH-1:0] DIV_DEFAULT = 16'd346;
    localparam logic [7:0] IDLE_DEFAULT = 8'd10;

    // Mark level of an uninverted line
    localparam logic LINE_IDLE = 1'b1;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

// File: src/cd_csr_pkg.sv
package cd_csr_pkg;

    typedef enum logic [4:0] {
        REG_VERSION       = 5'h00,
        REG_SETTING       = 5'h02,
        REG_IDLE_WAIT_LEN = 5'h04,
        REG_DIV_L         = 5'h0c,
        REG_DIV_H         = 5'h0d,
        REG_INT_MASK      = 5'h10,
        REG_INT_FLAG      = 5'h12,
        REG_RX_LEN        = 5'h14,
        REG_DAT           = 5'h15,
        REG_CTRL          = 5'h16
    } csr_addr_e;

    localparam logic [7:0] VERSION_VALUE = 8'h0f;

    // SETTING bits
    localparam int SET_TX_INVERT = 1;
    localparam int SET_RX_INVERT = 0;

    // CTRL bits
    localparam int CTRL_RX_CLEAN = 7;
    localparam int CTRL_RX_DONE  = 4;
    localparam int CTRL_TX_ABORT = 3;
    localparam int CTRL_TX_START = 0;

    // INT_FLAG and INT_MASK bits
    localparam int FLAG_RX_PENDING = 0;
    localparam int FLAG_RX_LOST    = 1;
    localparam int FLAG_TX_FREE    = 2;

    localparam logic [7:0] SETTING_DEFAULT  = 8'h00;
    localparam logic [7:0] INT_MASK_DEFAULT = 8'h00;

endpackage

// File: src/cd_tx_if.sv
`timescale 1ns/100ps

interface cd_tx_if import cd_bus_pkg::*; ();
    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [7:0]            wr_data;
    logic                  start;
    logic                  abort;
    logic                  invert;
    logic [DIV_WIDTH-1:0]  div;
    logic                  free;

    modport csr (
        output wr_en, wr_addr, wr_data, start, abort, invert, div,
        input  free
    );

    modport path (
        input  wr_en, wr_addr, wr_data, start, abort, invert, div,
        output free
    );
endinterface

// File: src/cd_rx_if.sv
`timescale 1ns/100ps

interface cd_rx_if import cd_bus_pkg::*; ();
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic                  done;
    logic                  clean;
    logic                  invert;
    logic [DIV_WIDTH-1:0]  div;
    logic [7:0]            idle_len;
    logic [7:0]            rd_byte;
    logic [ADDR_WIDTH-1:0] len;
    logic                  pending;
    logic                  lost;

    modport csr (
        output rd_addr, done, clean, invert, div, idle_len,
        input  rd_byte, len, pending, lost
    );

    modport path (
        input  rd_addr, done, clean, invert, div, idle_len,
        output rd_byte, len, pending, lost
    );
endinterface

// File: src/cd_csr.sv
`timescale 1ns/100ps

module cd_csr
    import cd_bus_pkg::*;
    import cd_csr_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  csr_addr_e  csr_address,
    input  logic       csr_read,
    input  logic       csr_write,
    input  logic [7:0] csr_writedata,
    output logic [7:0] csr_readdata,
    output logic       irq,
    cd_tx_if.csr       tx,
    cd_rx_if.csr       rx
);

    logic                  tx_invert;
    logic                  rx_invert;
    logic [7:0]            idle_len;
    logic [DIV_WIDTH-1:0]  div;
    logic [7:0]            int_mask;
    logic [7:0]            h_val_bkup;
    logic                  lost_flag;
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    logic [7:0]            int_flag;
    logic                  ctrl_wr;

    assign ctrl_wr = csr_write && (csr_address == REG_CTRL);

    always_comb begin
        int_flag = '0;
        int_flag[FLAG_RX_PENDING] = rx.pending;
        int_flag[FLAG_RX_LOST]    = lost_flag;
        int_flag[FLAG_TX_FREE]    = tx.free;
    end

    assign irq = |(int_flag & int_mask);

    // Strobes come straight from the bus cycle so start still sees the old write pointer
    assign tx.wr_en   = csr_write && (csr_address == REG_DAT);
    assign tx.wr_addr = wr_ptr;
    assign tx.wr_data = csr_writedata;
    assign tx.start   = ctrl_wr && csr_writedata[CTRL_TX_START];
    assign tx.abort   = ctrl_wr && csr_writedata[CTRL_TX_ABORT];
    assign tx.invert  = tx_invert;
    assign tx.div     = div;

    assign rx.rd_addr  = rd_ptr;
    assign rx.done     = ctrl_wr && csr_writedata[CTRL_RX_DONE];
    assign rx.clean    = ctrl_wr && csr_writedata[CTRL_RX_CLEAN];
    assign rx.invert   = rx_invert;
    assign rx.div      = div;
    assign rx.idle_len = idle_len;

    always_comb begin
        csr_readdata = '0;
        case (csr_address)
            REG_VERSION:
                csr_readdata = VERSION_VALUE;
            REG_SETTING: begin
                csr_readdata[SET_TX_INVERT] = tx_invert;
                csr_readdata[SET_RX_INVERT] = rx_invert;
            end
            REG_IDLE_WAIT_LEN:
                csr_readdata = idle_len;
            REG_DIV_L:
                csr_readdata = div[7:0];
            REG_DIV_H:
                csr_readdata = div[15:8];
            REG_INT_MASK:
                csr_readdata = int_mask;
            REG_INT_FLAG:
                csr_readdata = int_flag;
            REG_RX_LEN:
                csr_readdata = rx.len;
            REG_DAT:
                csr_readdata = rx.rd_byte;
            default:
                csr_readdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tx_invert  <= SETTING_DEFAULT[SET_TX_INVERT];
            rx_invert  <= SETTING_DEFAULT[SET_RX_INVERT];
            idle_len   <= IDLE_DEFAULT;
            div        <= DIV_DEFAULT;
            int_mask   <= INT_MASK_DEFAULT;
            h_val_bkup <= '0;
            lost_flag  <= 1'b0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
        end else begin
            // High byte only survives until the very next access
            if (csr_read || csr_write)
                h_val_bkup <= '0;

            if (csr_read && csr_address == REG_INT_FLAG)
                lost_flag <= 1'b0;
            if (rx.lost)
                lost_flag <= 1'b1;

            if (csr_read && csr_address == REG_DAT)
                rd_ptr <= rd_ptr + 1'b1;

            if (csr_write) begin
                case (csr_address)
                    REG_SETTING: begin
                        tx_invert <= csr_writedata[SET_TX_INVERT];
                        rx_invert <= csr_writedata[SET_RX_INVERT];
                    end
                    REG_IDLE_WAIT_LEN:
                        idle_len <= csr_writedata;
                    REG_DIV_L:
                        div <= {h_val_bkup, csr_writedata};
                    REG_DIV_H:
                        h_val_bkup <= csr_writedata;
                    REG_INT_MASK:
                        int_mask <= csr_writedata;
                    REG_DAT:
                        wr_ptr <= wr_ptr + 1'b1;
                    REG_CTRL: begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: src/cd_tx_path.sv
`timescale 1ns/100ps

module cd_tx_path import cd_bus_pkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    cd_tx_if.path tx,
    output logic  tx_line
);

    logic [7:0]                   mem [BUF_DEPTH];
    tx_state_e                    state;
    logic [DIV_WIDTH-1:0]         div_cnt;
    logic [$clog2(DATA_BITS)-1:0] bit_cnt;
    logic [ADDR_WIDTH-1:0]        byte_idx;
    logic [ADDR_WIDTH-1:0]        len;
    logic [7:0]                   shift;
    logic                         line_q;
    logic                         bit_end;

    assign bit_end = div_cnt >= tx.div;
    assign tx.free = state == TX_IDLE;
    assign tx_line = line_q ^ tx.invert;

    // Buffer fills only while nothing is in flight
    always_ff @(posedge clk) begin
        if (tx.wr_en && tx.free)
            mem[tx.wr_addr] <= tx.wr_data;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= TX_IDLE;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            byte_idx <= '0;
            len      <= '0;
            shift    <= '0;
            line_q   <= LINE_IDLE;
        end else if (tx.abort) begin
            state   <= TX_IDLE;
            div_cnt <= '0;
            line_q  <= LINE_IDLE;
        end else begin
            div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    div_cnt <= '0;
                    if (tx.start && tx.wr_addr != '0) begin
                        len      <= tx.wr_addr;
                        byte_idx <= '0;
                        line_q   <= ~LINE_IDLE;
                        state    <= TX_START;
                    end
                end
                TX_START: if (bit_end) begin
                    shift   <= mem[byte_idx];
                    line_q  <= mem[byte_idx][0];
                    bit_cnt <= '0;
                    state   <= TX_DATA;
                end
                TX_DATA: if (bit_end) begin
                    if (bit_cnt == DATA_BITS - 1) begin
                        line_q <= LINE_IDLE;
                        state  <= TX_STOP;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        shift   <= shift >> 1;
                        line_q  <= shift[1];
                    end
                end
                TX_STOP: if (bit_end) begin
                    if (byte_idx == len - 1'b1) begin
                        state <= TX_IDLE;
                    end else begin
                        byte_idx <= byte_idx + 1'b1;
                        line_q   <= ~LINE_IDLE;
                        state    <= TX_START;
                    end
                end
            endcase
        end
    end

endmodule

// File: src/cd_rx_path.sv
`timescale 1ns/100ps

module cd_rx_path import cd_bus_pkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    input  logic  rx_line,
    cd_rx_if.path rx
);

    logic [7:0]                   mem [BUF_DEPTH];
    rx_state_e                    state;
    logic [1:0]                   sync;
    logic                         rx_bit;
    logic [DIV_WIDTH-1:0]         div_cnt;
    logic [$clog2(DATA_BITS)-1:0] bit_cnt;
    logic [7:0]                   idle_cnt;
    logic [7:0]                   shift;
    logic [ADDR_WIDTH-1:0]        wr_ptr;
    logic [ADDR_WIDTH-1:0]        len_q;
    logic                         in_frame;
    logic                         pending_q;
    logic                         lost_q;
    logic                         bit_end;
    logic                         byte_done;

    assign rx_bit     = sync[1] ^ rx.invert;
    assign bit_end    = div_cnt >= rx.div;
    assign byte_done  = state == RX_STOP && bit_end && rx_bit == LINE_IDLE;
    assign rx.rd_byte = mem[rx.rd_addr];
    assign rx.len     = len_q;
    assign rx.pending = pending_q;
    assign rx.lost    = lost_q;

    // Held frame is protected while pending
    always_ff @(posedge clk) begin
        if (byte_done && !pending_q)
            mem[wr_ptr] <= shift;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sync      <= {LINE_IDLE, LINE_IDLE};
            state     <= RX_IDLE;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            idle_cnt  <= '0;
            shift     <= '0;
            wr_ptr    <= '0;
            len_q     <= '0;
            in_frame  <= 1'b0;
            pending_q <= 1'b0;
            lost_q    <= 1'b0;
        end else begin
            sync    <= {sync[0], rx_line};
            lost_q  <= 1'b0;
            div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
            if (rx.done || rx.clean)
                pending_q <= 1'b0;
            if (rx.clean)
                len_q <= '0;

            case (state)
                RX_IDLE: begin
                    if (rx_bit != LINE_IDLE) begin
                        div_cnt  <= '0;
                        idle_cnt <= '0;
                        state    <= RX_START;
                    end else if (!in_frame) begin
                        div_cnt <= '0;
                    end else if (bit_end) begin
                        idle_cnt <= idle_cnt + 1'b1;
                        // Bus stayed idle long enough to close the frame
                        if (idle_cnt == rx.idle_len - 1'b1) begin
                            in_frame <= 1'b0;
                            wr_ptr   <= '0;
                            idle_cnt <= '0;
                            if (pending_q) begin
                                lost_q <= 1'b1;
                            end else begin
                                pending_q <= 1'b1;
                                len_q     <= wr_ptr;
                            end
                        end
                    end
                end
                RX_START: if (div_cnt >= (rx.div >> 1)) begin
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    state   <= (rx_bit != LINE_IDLE) ? RX_DATA : RX_IDLE;
                end
                RX_DATA: if (bit_end) begin
                    shift <= {rx_bit, shift[7:1]};
                    if (bit_cnt == DATA_BITS - 1)
                        state <= RX_STOP;
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
                RX_STOP: if (bit_end) begin
                    state <= RX_IDLE;
                    if (byte_done) begin
                        in_frame <= 1'b1;
                        if (!pending_q)
                            wr_ptr <= wr_ptr + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// File: src/cd_ctrl_top.sv
`timescale 1ns/100ps

module cd_ctrl_top import cd_csr_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic [4:0] csr_address,
    input  logic       csr_read,
    input  logic       csr_write,
    input  logic [7:0] csr_writedata,
    output logic [7:0] csr_readdata,
    output logic       irq,
    output logic       tx_line,
    input  logic       rx_line
);

    cd_tx_if tx_bus ();
    cd_rx_if rx_bus ();

    cd_csr u_csr (
        .clk           (clk),
        .reset_n       (reset_n),
        .csr_address   (csr_addr_e'(csr_address)),
        .csr_read      (csr_read),
        .csr_write     (csr_write),
        .csr_writedata (csr_writedata),
        .csr_readdata  (csr_readdata),
        .irq           (irq),
        .tx            (tx_bus.csr),
        .rx            (rx_bus.csr)
    );

    cd_tx_path u_tx_path (
        .clk     (clk),
        .reset_n (reset_n),
        .tx      (tx_bus.path),
        .tx_line (tx_line)
    );

    cd_rx_path u_rx_path (
        .clk     (clk),
        .reset_n (reset_n),
        .rx_line (rx_line),
        .rx      (rx_bus.path)
    );

endmodule

// File: tests/cd_ctrl_properties.sv
`timescale 1ns/100ps

module cd_ctrl_properties import cd_csr_pkg::*; (
    input logic       clk,
    input logic       reset_n,
    input logic [7:0] int_flag,
    input logic       tx_wr_en,
    input logic       tx_start,
    input logic       rx_lost
);

    int fail_count = 0;

    assert property (@(posedge clk) disable iff (!reset_n) tx_wr_en |=> !tx_wr_en)
        else begin
            $error("tx wr_en held high for two cycles");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!reset_n) tx_start |=> !tx_start)
        else begin
            $error("tx start held high for two cycles");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!reset_n)
        rx_lost |=> int_flag[FLAG_RX_LOST])
        else begin
            $error("lost pulse did not set the lost flag");
            fail_count++;
        end

endmodule

bind cd_csr cd_ctrl_properties u_properties (
    .clk      (clk),
    .reset_n  (reset_n),
    .int_flag (int_flag),
    .tx_wr_en (tx.wr_en),
    .tx_start (tx.start),
    .rx_lost  (rx.lost)
);

// File: tests/tb_cd_ctrl.sv
`timescale 1ns/100ps

module tb_cd_ctrl import cd_csr_pkg::*; ();

    localparam int HALF_PERIOD = 20;
    localparam int WAIT_LIMIT  = 1000;
    localparam int PAT_WORDS   = 13;
    localparam int IDX_FRAME_A = 4;
    localparam int IDX_FRAME_B = 9;

    logic       clk;
    logic       reset_n;
    logic [4:0] csr_address;
    logic       csr_read;
    logic       csr_write;
    logic [7:0] csr_writedata;
    logic [7:0] csr_readdata;
    logic       irq;
    logic       tx_line;
    logic       rx_line;

    logic [7:0] pat [PAT_WORDS];
    int         test_errors;
    int         total_errors;
    int         failed_tests;
    bit         aborted;

    cd_ctrl_top UUT (
        .clk           (clk),
        .reset_n       (reset_n),
        .csr_address   (csr_address),
        .csr_read      (csr_read),
        .csr_write     (csr_write),
        .csr_writedata (csr_writedata),
        .csr_readdata  (csr_readdata),
        .irq           (irq),
        .tx_line       (tx_line),
        .rx_line       (rx_line)
    );

    // Serial loopback
    assign rx_line = tx_line;

    always #HALF_PERIOD clk = ~clk;

    // Bus tasks are entered on a falling edge and return on one
    task automatic csr_wr(input csr_addr_e addr, input logic [7:0] data);
        csr_address   = addr;
        csr_writedata = data;
        csr_write     = 1'b1;
        @(negedge clk);
        csr_write = 1'b0;
        // Idle cycle between bus writes
        @(negedge clk);
    endtask

    task automatic csr_rd(input csr_addr_e addr, output logic [7:0] data);
        csr_address = addr;
        csr_read    = 1'b1;
        #(HALF_PERIOD / 2);
        data = csr_readdata;
        @(negedge clk);
        csr_read = 1'b0;
    endtask

    task automatic check_val(input string what, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            $display("ERROR %0t: %s read 0x%02h, expected 0x%02h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic wait_flag(input int flag_bit, input string what);
        logic [7:0] flags;
        int         cnt;
        flags = '0;
        cnt   = 0;
        while (!flags[flag_bit] && cnt < WAIT_LIMIT) begin
            csr_rd(REG_INT_FLAG, flags);
            cnt++;
        end
        if (!flags[flag_bit]) begin
            $display("timeout waiting for %s", what);
            aborted = 1'b1;
        end
    endtask

    task automatic send_frame(input int base);
        int len;
        len = pat[base];
        for (int i = 0; i < len; i++)
            csr_wr(REG_DAT, pat[base + 1 + i]);
        csr_wr(REG_CTRL, 8'h01 << CTRL_TX_START);
    endtask

    task automatic check_frame(input int base);
        logic [7:0] got;
        int         len;
        len = pat[base];
        csr_rd(REG_RX_LEN, got);
        check_val("RX_LEN", got, pat[base]);
        for (int i = 0; i < len; i++) begin
            csr_rd(REG_DAT, got);
            check_val("DAT", got, pat[base + 1 + i]);
        end
    endtask

    task automatic finish_test(input string name);
        if (aborted)
            $display("test %s: aborted", name);
        else
            $display("test %s: %0d errors", name, test_errors);
        if (aborted || test_errors != 0)
            failed_tests++;
        total_errors += test_errors;
        test_errors = 0;
    endtask

    initial begin : main_seq
        logic [7:0] got;
        clk           = 1'b0;
        reset_n       = 1'b0;
        csr_address   = '0;
        csr_read      = 1'b0;
        csr_write     = 1'b0;
        csr_writedata = '0;
        test_errors   = 0;
        total_errors  = 0;
        failed_tests  = 0;
        aborted       = 1'b0;
        $readmemh("tests/cd_patterns.txt", pat);
        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        csr_rd(REG_VERSION, got);
        check_val("VERSION", got, pat[0]);
        csr_rd(REG_DIV_L, got);
        check_val("DIV_L", got, pat[1]);
        csr_rd(REG_DIV_H, got);
        check_val("DIV_H", got, pat[2]);
        csr_rd(REG_INT_FLAG, got);
        check_val("INT_FLAG", got, pat[3]);
        check_val("irq", {7'd0, irq}, 8'h00);
        finish_test("1 reset values");

        csr_wr(REG_DIV_H, 8'h12);
        csr_wr(REG_DIV_L, 8'h34);
        csr_rd(REG_DIV_L, got);
        check_val("DIV_L", got, 8'h34);
        csr_rd(REG_DIV_H, got);
        check_val("DIV_H", got, 8'h12);
        // Backup is gone, so the high byte falls to zero
        csr_wr(REG_DIV_L, 8'h56);
        csr_rd(REG_DIV_L, got);
        check_val("DIV_L", got, 8'h56);
        csr_rd(REG_DIV_H, got);
        check_val("DIV_H", got, 8'h00);
        finish_test("2 split divider write");

        csr_wr(REG_DIV_H, 8'h00);
        csr_wr(REG_DIV_L, 8'h07);
        csr_wr(REG_IDLE_WAIT_LEN, 8'h03);
        send_frame(IDX_FRAME_A);
        wait_flag(FLAG_RX_PENDING, "rx pending");
        if (!aborted)
            check_frame(IDX_FRAME_A);
        finish_test("3 loopback frame");

        if (!aborted) begin
            check_val("irq with mask clear", {7'd0, irq}, 8'h00);
            csr_wr(REG_INT_MASK, 8'h01 << FLAG_RX_PENDING);
            check_val("irq with pending masked in", {7'd0, irq}, 8'h01);
            csr_wr(REG_CTRL, 8'h01 << CTRL_RX_DONE);
            check_val("irq after rx done", {7'd0, irq}, 8'h00);
            csr_wr(REG_INT_MASK, 8'h00);
            check_val("irq with mask zero", {7'd0, irq}, 8'h00);
        end
        finish_test("4 interrupt masking");

        if (!aborted) begin
            send_frame(IDX_FRAME_A);
            wait_flag(FLAG_RX_PENDING, "rx pending");
        end
        if (!aborted) begin
            send_frame(IDX_FRAME_B);
            wait_flag(FLAG_RX_LOST, "rx lost");
        end
        if (!aborted) begin
            check_frame(IDX_FRAME_A);
            csr_rd(REG_INT_FLAG, got);
            check_val("INT_FLAG after lost read", got,
                      (8'h01 << FLAG_RX_PENDING) | (8'h01 << FLAG_TX_FREE));
            csr_wr(REG_CTRL, 8'h01 << CTRL_RX_DONE);
        end
        finish_test("5 overrun");

        if (!aborted) begin
            csr_wr(REG_SETTING, (8'h01 << SET_TX_INVERT) | (8'h01 << SET_RX_INVERT));
            check_val("tx_line idle level", {7'd0, tx_line}, 8'h00);
            send_frame(IDX_FRAME_B);
            wait_flag(FLAG_RX_PENDING, "rx pending");
        end
        if (!aborted)
            check_frame(IDX_FRAME_B);
        finish_test("6 inversion");

        total_errors += UUT.u_csr.u_properties.fail_count;
        $display("tests run: 6, tests with errors: %0d, failed checks: %0d",
                 failed_tests, total_errors);
        if (!aborted && total_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: tests/cd_patterns.txt
// One hex byte per line: reset reads of VERSION, DIV_L, DIV_H and INT_FLAG,
// then frame A (length, bytes), then frame B (length, bytes)
0f
5a
01
04
04
a5
3c
00
ff
03
81
7e
12

// File: list.f
src/cd_bus_pkg.sv
src/cd_csr_pkg.sv
src/cd_tx_if.sv
src/cd_rx_if.sv
src/cd_csr.sv
src/cd_tx_path.sv
src/cd_rx_path.sv
src/cd_ctrl_top.sv
tests/cd_ctrl_properties.sv
tests/tb_cd_ctrl.sv
